// File: common/cpu_pkg.sv
package cpu_pkg;

    localparam int WORD_W    = 32;
    localparam int REG_IDX_W = 5;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [WORD_W/8-1:0]  wen_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } alu_op_t;

    // primary opcodes, instr[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // function codes under OP_SPECIAL, instr[5:0]
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

endpackage

// File: common/fetch_if.sv
`timescale 1ns/1ps

interface fetch_if;
    import cpu_pkg::*;

    logic  en;
    word_t addr;
    word_t rdata;
    logic  stall;

    modport core (
        output en,
        output addr,
        input  rdata,
        input  stall
    );

    modport cache (
        input  en,
        input  addr,
        output rdata,
        output stall
    );

endinterface

// File: common/data_if.sv
`timescale 1ns/1ps

interface data_if;
    import cpu_pkg::*;

    logic  en;
    // nonzero means store
    wen_t  wen;
    word_t addr;
    word_t wdata;
    word_t rdata;
    logic  stall;

    modport core (
        output en,
        output wen,
        output addr,
        output wdata,
        input  rdata,
        input  stall
    );

    modport cache (
        input  en,
        input  wen,
        input  addr,
        input  wdata,
        output rdata,
        output stall
    );

endinterface

// File: datapath/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic              clk,
    input  logic              rst,
    input  cpu_pkg::reg_idx_t ra1,
    input  cpu_pkg::reg_idx_t ra2,
    output cpu_pkg::word_t    rd1,
    output cpu_pkg::word_t    rd2,
    input  logic              we,
    input  cpu_pkg::reg_idx_t wa,
    input  cpu_pkg::word_t    wd
);
    import cpu_pkg::*;

    word_t regs [32];

    // $0 is never stored
    always_ff @(posedge clk) begin
        if (we && !rst && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule

// File: datapath/datapath.sv
`timescale 1ns/1ps

module datapath #(
    parameter cpu_pkg::word_t reset_pc = 32'hbfc0_0000
) (
    input  logic              clk,
    input  logic              rst,
    fetch_if.core             fetch,
    data_if.core              dmem,
    output cpu_pkg::word_t    debug_wb_pc,
    output cpu_pkg::wen_t     debug_wb_rf_wen,
    output cpu_pkg::reg_idx_t debug_wb_rf_wnum,
    output cpu_pkg::word_t    debug_wb_rf_wdata
);
    import cpu_pkg::*;

    typedef enum logic [1:0] {PH_FETCH, PH_EXEC, PH_MEM, PH_WB} phase_t;

    phase_t   phase;
    word_t    pc;
    word_t    npc;
    word_t    ir;
    word_t    res;
    word_t    wb_data;
    reg_idx_t wb_num;
    logic     wb_we;

    logic [5:0]  op;
    logic [5:0]  funct;
    reg_idx_t    rs;
    reg_idx_t    rt;
    reg_idx_t    rd;
    reg_idx_t    dst;
    logic [15:0] imm;
    logic [25:0] jidx;

    word_t rd1;
    word_t rd2;
    word_t imm_sext;
    word_t imm_ext;
    word_t alu_b;
    word_t alu_y;
    word_t pc_plus4;
    word_t br_target;

    alu_op_t    alu_op;
    logic [5:0] ctrl;
    logic       reg_write;
    logic       dst_rt;
    logic       use_imm;
    logic       zero_ext;
    logic       mem_rd;
    logic       mem_wr;
    logic       take_branch;
    logic       jump;

    assign op    = ir[31:26];
    assign rs    = ir[25:21];
    assign rt    = ir[20:16];
    assign rd    = ir[15:11];
    assign imm   = ir[15:0];
    assign funct = ir[5:0];
    assign jidx  = ir[25:0];

    regfile regfile (
        .clk(clk),
        .rst(rst),
        .ra1(rs),
        .ra2(rt),
        .rd1(rd1),
        .rd2(rd2),
        .we (phase == PH_WB && wb_we),
        .wa (wb_num),
        .wd (wb_data)
    );

    assign {reg_write, dst_rt, use_imm, zero_ext, mem_rd, mem_wr} = ctrl;

    always_comb begin
        alu_op      = ALU_ADD;
        ctrl        = 6'b000000;
        take_branch = 1'b0;
        jump        = 1'b0;
        case (op)
            OP_SPECIAL: begin
                ctrl = 6'b100000;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    // unknown function acts as a nop
                    default: ctrl = 6'b000000;
                endcase
            end
            OP_ADDIU: ctrl = 6'b111000;
            OP_ORI: begin
                ctrl   = 6'b111100;
                alu_op = ALU_OR;
            end
            OP_LUI: begin
                ctrl   = 6'b111000;
                alu_op = ALU_LUI;
            end
            OP_LW:   ctrl = 6'b111010;
            OP_SW:   ctrl = 6'b001001;
            OP_BEQ:  take_branch = (rd1 == rd2);
            OP_BNE:  take_branch = (rd1 != rd2);
            OP_J:    jump = 1'b1;
            default: ctrl = 6'b000000;
        endcase
    end

    assign imm_sext  = {{16{imm[15]}}, imm};
    assign imm_ext   = zero_ext ? {16'h0000, imm} : imm_sext;
    assign alu_b     = use_imm ? imm_ext : rd2;
    assign dst       = dst_rt ? rt : rd;
    assign pc_plus4  = pc + 32'd4;
    assign br_target = pc_plus4 + {imm_sext[29:0], 2'b00};

    always_comb begin
        case (alu_op)
            ALU_ADD: alu_y = rd1 + alu_b;
            ALU_SUB: alu_y = rd1 - alu_b;
            ALU_AND: alu_y = rd1 & alu_b;
            ALU_OR:  alu_y = rd1 | alu_b;
            ALU_SLT: alu_y = {31'b0, $signed(rd1) < $signed(alu_b)};
            ALU_LUI: alu_y = {imm, 16'h0000};
            default: alu_y = '0;
        endcase
    end

    // reset lands in write-back with no write, so pc loads reset_pc once more
    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= PH_WB;
            pc    <= reset_pc;
            npc   <= reset_pc;
            wb_we <= 1'b0;
        end else begin
            case (phase)
                PH_FETCH: begin
                    if (!fetch.stall) begin
                        phase <= PH_EXEC;
                    end
                end
                PH_EXEC: begin
                    wb_we <= reg_write && (dst != 5'd0);
                    if (jump) begin
                        npc <= {pc_plus4[31:28], jidx, 2'b00};
                    end else begin
                        npc <= take_branch ? br_target : pc_plus4;
                    end
                    phase <= (mem_rd || mem_wr) ? PH_MEM : PH_WB;
                end
                PH_MEM: begin
                    if (!dmem.stall) begin
                        phase <= PH_WB;
                    end
                end
                default: begin
                    pc    <= npc;
                    phase <= PH_FETCH;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase == PH_FETCH && !fetch.stall) begin
            ir <= fetch.rdata;
        end
        if (phase == PH_EXEC) begin
            res     <= alu_y;
            wb_data <= alu_y;
            wb_num  <= dst;
        end
        if (phase == PH_MEM && !dmem.stall && mem_rd) begin
            wb_data <= dmem.rdata;
        end
    end

    assign fetch.en   = (phase == PH_FETCH);
    assign fetch.addr = pc;

    assign dmem.en    = (phase == PH_MEM);
    assign dmem.wen   = mem_wr ? 4'b1111 : 4'b0000;
    assign dmem.addr  = res;
    assign dmem.wdata = rd2;

    // trace is valid only in the write-back cycle
    assign debug_wb_pc       = pc;
    assign debug_wb_rf_wen   = (phase == PH_WB && wb_we) ? 4'b1111 : 4'b0000;
    assign debug_wb_rf_wnum  = wb_num;
    assign debug_wb_rf_wdata = wb_data;

endmodule

// File: cache/i_cache.sv
`timescale 1ns/1ps

module i_cache #(
    parameter int ic_index_bits = 4
) (
    input  logic           clk,
    input  logic           rst,
    fetch_if.cache         fetch,
    output logic           inst_sram_en,
    output cpu_pkg::word_t inst_sram_addr,
    input  cpu_pkg::word_t inst_sram_rdata
);
    import cpu_pkg::*;

    localparam int LINES = 1 << ic_index_bits;
    localparam int TAG_W = 30 - ic_index_bits;

    // wait: sram data arrives, fill: line just written, answers as a hit
    typedef enum logic [1:0] {IC_IDLE, IC_WAIT, IC_FILL} ic_state_t;

    ic_state_t              state;
    logic [LINES-1:0]       valid;
    logic [TAG_W-1:0]       tags [LINES];
    word_t                  lines [LINES];
    logic [ic_index_bits-1:0] index;
    logic [TAG_W-1:0]       tag;
    logic                   hit;

    assign index = fetch.addr[ic_index_bits+1:2];
    assign tag   = fetch.addr[31:ic_index_bits+2];
    assign hit   = valid[index] && (tags[index] == tag);

    assign fetch.stall = fetch.en && !hit;
    assign fetch.rdata = lines[index];

    // one-cycle request pulse per miss
    assign inst_sram_en   = fetch.en && !hit && (state == IC_IDLE);
    assign inst_sram_addr = {fetch.addr[31:2], 2'b00};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IC_IDLE;
            valid <= '0;
        end else begin
            case (state)
                IC_IDLE: begin
                    if (inst_sram_en) begin
                        state <= IC_WAIT;
                    end
                end
                IC_WAIT: begin
                    valid[index] <= 1'b1;
                    state        <= IC_FILL;
                end
                default: state <= IC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IC_WAIT) begin
            tags[index]  <= tag;
            lines[index] <= inst_sram_rdata;
        end
    end

endmodule

// File: cache/d_cache.sv
`timescale 1ns/1ps

module d_cache #(
    parameter int dc_index_bits = 4
) (
    input  logic           clk,
    input  logic           rst,
    data_if.cache          dmem,
    output logic           data_sram_en,
    output cpu_pkg::wen_t  data_sram_wen,
    output cpu_pkg::word_t data_sram_addr,
    output cpu_pkg::word_t data_sram_wdata,
    input  cpu_pkg::word_t data_sram_rdata,
    input  logic           data_sram_data_ok
);
    import cpu_pkg::*;

    localparam int LINES = 1 << dc_index_bits;
    localparam int TAG_W = 30 - dc_index_bits;

    typedef enum logic {DC_IDLE, DC_DONE} dc_state_t;

    dc_state_t                state;
    logic [LINES-1:0]         valid;
    logic [TAG_W-1:0]         tags [LINES];
    word_t                    lines [LINES];
    word_t                    rdata_q;
    logic [dc_index_bits-1:0] index;
    logic [TAG_W-1:0]         tag;
    logic                     hit;
    logic                     uncached;
    logic                     is_store;
    logic                     need_sram;
    logic                     done;
    logic                     fill;
    logic                     upd;

    assign index    = dmem.addr[dc_index_bits+1:2];
    assign tag      = dmem.addr[31:dc_index_bits+2];
    assign hit      = valid[index] && (tags[index] == tag);
    // kseg1 goes straight to memory
    assign uncached = (dmem.addr[31:29] == 3'b101);
    assign is_store = (dmem.wen != 4'b0000);

    // loads that hit are the only accesses served locally
    assign need_sram = dmem.en && (uncached || is_store || !hit);

    assign data_sram_en    = need_sram && (state != DC_DONE);
    assign data_sram_wen   = data_sram_en ? dmem.wen : 4'b0000;
    assign data_sram_addr  = {dmem.addr[31:2], 2'b00};
    assign data_sram_wdata = dmem.wdata;

    assign done = data_sram_en && data_sram_data_ok;
    // no allocate on a store miss
    assign fill = done && !uncached && !is_store;
    assign upd  = done && !uncached && is_store && hit;

    // stall holds through the data_ok cycle and drops in DONE
    assign dmem.stall = data_sram_en;
    assign dmem.rdata = (state == DC_DONE) ? rdata_q : lines[index];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= DC_IDLE;
            valid <= '0;
        end else begin
            case (state)
                DC_IDLE: begin
                    if (done) begin
                        state <= DC_DONE;
                    end
                end
                default: state <= DC_IDLE;
            endcase
            if (fill) begin
                valid[index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tags[index]  <= tag;
            lines[index] <= data_sram_rdata;
        end else if (upd) begin
            for (int i = 0; i < $bits(wen_t); i++) begin
                if (dmem.wen[i]) begin
                    lines[index][8*i +: 8] <= dmem.wdata[8*i +: 8];
                end
            end
        end
        if (done) begin
            rdata_q <= data_sram_rdata;
        end
    end

endmodule

// File: src/mycpu_top.sv
`timescale 1ns/1ps

module mycpu_top #(
    parameter cpu_pkg::word_t reset_pc      = 32'hbfc0_0000,
    parameter int             ic_index_bits = 4,
    parameter int             dc_index_bits = 4
) (
    input  logic                clk,
    input  logic                rst,

    output logic                inst_sram_en,
    output cpu_pkg::wen_t       inst_sram_wen,
    output cpu_pkg::word_t      inst_sram_addr,
    output cpu_pkg::word_t      inst_sram_wdata,
    input  cpu_pkg::word_t      inst_sram_rdata,

    output logic                data_sram_en,
    output cpu_pkg::wen_t       data_sram_wen,
    output cpu_pkg::word_t      data_sram_addr,
    output cpu_pkg::word_t      data_sram_wdata,
    input  cpu_pkg::word_t      data_sram_rdata,
    input  logic                data_sram_data_ok,

    output cpu_pkg::word_t      debug_wb_pc,
    output cpu_pkg::wen_t       debug_wb_rf_wen,
    output cpu_pkg::reg_idx_t   debug_wb_rf_wnum,
    output cpu_pkg::word_t      debug_wb_rf_wdata
);
    import cpu_pkg::*;

    word_t inst_vaddr;
    word_t data_vaddr;

    fetch_if fetch_bus ();
    data_if  data_bus ();

    // kseg0 and kseg1 both map onto the low 512MB
    function automatic word_t to_phys(input word_t vaddr);
        return (vaddr[31:30] == 2'b10) ? {3'b000, vaddr[28:0]} : vaddr;
    endfunction

    // instruction port never writes
    assign inst_sram_wen   = 4'b0000;
    assign inst_sram_wdata = 32'h0;

    datapath #(
        .reset_pc(reset_pc)
    ) datapath (
        .clk              (clk),
        .rst              (rst),
        .fetch            (fetch_bus.core),
        .dmem             (data_bus.core),
        .debug_wb_pc      (debug_wb_pc),
        .debug_wb_rf_wen  (debug_wb_rf_wen),
        .debug_wb_rf_wnum (debug_wb_rf_wnum),
        .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

    i_cache #(
        .ic_index_bits(ic_index_bits)
    ) i_cache (
        .clk            (clk),
        .rst            (rst),
        .fetch          (fetch_bus.cache),
        .inst_sram_en   (inst_sram_en),
        .inst_sram_addr (inst_vaddr),
        .inst_sram_rdata(inst_sram_rdata)
    );

    d_cache #(
        .dc_index_bits(dc_index_bits)
    ) d_cache (
        .clk              (clk),
        .rst              (rst),
        .dmem             (data_bus.cache),
        .data_sram_en     (data_sram_en),
        .data_sram_wen    (data_sram_wen),
        .data_sram_addr   (data_vaddr),
        .data_sram_wdata  (data_sram_wdata),
        .data_sram_rdata  (data_sram_rdata),
        .data_sram_data_ok(data_sram_data_ok)
    );

    assign inst_sram_addr = to_phys(inst_vaddr);
    assign data_sram_addr = to_phys(data_vaddr);

endmodule

// File: bench/sram_model.sv
`timescale 1ns/1ps

module sram_model (
    input  logic           clk,
    input  logic           rst,
    input  logic           inst_en,
    input  cpu_pkg::word_t inst_addr,
    output cpu_pkg::word_t inst_rdata,
    input  logic           data_en,
    input  cpu_pkg::wen_t  data_wen,
    input  cpu_pkg::word_t data_addr,
    input  cpu_pkg::word_t data_wdata,
    output cpu_pkg::word_t data_rdata,
    output logic           data_ok
);
    import cpu_pkg::*;

    localparam int          DEPTH     = 1024;
    localparam logic [19:0] INST_PAGE = 20'h1fc00;

    word_t imem [DEPTH];
    word_t dmem [DEPTH];
    int    inst_reads [DEPTH];
    int    data_reads [DEPTH];
    int    data_writes [DEPTH];
    int    inst_stray;
    int    data_stray;

    logic [15:0] lfsr;
    logic        busy;
    logic [1:0]  wait_cnt;
    logic [9:0]  didx;

    assign didx = data_addr[11:2];

    // 16-bit Galois LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    initial begin
        inst_rdata <= '0;
        data_rdata <= '0;
        data_ok    <= 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            imem[i] = {INST_PAGE, i[9:0], 2'b00} ^ 32'ha5a5_a5a5;
            dmem[i] = {20'h00000, i[9:0], 2'b00} ^ 32'ha5a5_a5a5;
        end
    end

    // instruction port answers one cycle after en
    always @(posedge clk) begin
        if (rst) begin
            inst_stray <= 0;
            for (int i = 0; i < DEPTH; i++) begin
                inst_reads[i] <= 0;
            end
        end else if (inst_en) begin
            inst_rdata <= imem[inst_addr[11:2]];
            if (inst_addr[31:12] == INST_PAGE) begin
                inst_reads[inst_addr[11:2]] <= inst_reads[inst_addr[11:2]] + 1;
            end else begin
                inst_stray <= inst_stray + 1;
            end
        end
    end

    always @(posedge clk) begin
        logic [1:0] delay;
        if (rst) begin
            lfsr       = 16'd34945;
            busy       <= 1'b0;
            wait_cnt   <= 2'd0;
            data_ok    <= 1'b0;
            data_stray <= 0;
            for (int i = 0; i < DEPTH; i++) begin
                data_reads[i]  <= 0;
                data_writes[i] <= 0;
            end
        end else if (data_ok) begin
            data_ok <= 1'b0;
            busy    <= 1'b0;
        end else if (data_en && !busy) begin
            // one step per delay bit
            delay[0] = lfsr[0];
            lfsr     = lfsr_step(lfsr);
            delay[1] = lfsr[0];
            lfsr     = lfsr_step(lfsr);
            if (data_addr[31:12] != 20'h00000) begin
                data_stray <= data_stray + 1;
            end
            if (data_wen != 4'b0000) begin
                for (int b = 0; b < 4; b++) begin
                    if (data_wen[b]) begin
                        dmem[didx][8*b +: 8] = data_wdata[8*b +: 8];
                    end
                end
                data_writes[didx] <= data_writes[didx] + 1;
            end else begin
                data_reads[didx] <= data_reads[didx] + 1;
            end
            if (delay == 2'd0) begin
                data_ok    <= 1'b1;
                data_rdata <= dmem[didx];
            end else begin
                busy     <= 1'b1;
                wait_cnt <= delay;
            end
        end else if (busy) begin
            if (wait_cnt == 2'd1) begin
                data_ok    <= 1'b1;
                data_rdata <= dmem[didx];
            end
            wait_cnt <= wait_cnt - 2'd1;
        end
    end

endmodule

// File: bench/tb_top.sv
`timescale 1ns/1ps

module tb_top;
    import cpu_pkg::*;

    localparam int    PROG_LEN    = 22;
    localparam int    TRACE_LEN   = 22;
    localparam int    WAIT_LIMIT  = 400;
    localparam int    SPIN_CYCLES = 24;
    localparam int    IDX_CACHED  = 'h100 >> 2;
    localparam int    IDX_RESULT  = 'h104 >> 2;
    localparam int    IDX_KSEG1   = 'h200 >> 2;
    localparam word_t KSEG1_WORD  = 32'h600d_f00d;

    typedef struct packed {
        word_t    pc;
        reg_idx_t num;
        word_t    data;
    } trace_t;

    logic     clk;
    logic     rst;
    logic     inst_sram_en;
    wen_t     inst_sram_wen;
    word_t    inst_sram_addr;
    word_t    inst_sram_wdata;
    word_t    inst_sram_rdata;
    logic     data_sram_en;
    wen_t     data_sram_wen;
    word_t    data_sram_addr;
    word_t    data_sram_wdata;
    word_t    data_sram_rdata;
    logic     data_sram_data_ok;
    word_t    debug_wb_pc;
    wen_t     debug_wb_rf_wen;
    reg_idx_t debug_wb_rf_wnum;
    word_t    debug_wb_rf_wdata;

    word_t  prog [PROG_LEN];
    trace_t trace [TRACE_LEN];
    int     errors;
    int     timeouts;

    mycpu_top dut0 (
        .clk              (clk),
        .rst              (rst),
        .inst_sram_en     (inst_sram_en),
        .inst_sram_wen    (inst_sram_wen),
        .inst_sram_addr   (inst_sram_addr),
        .inst_sram_wdata  (inst_sram_wdata),
        .inst_sram_rdata  (inst_sram_rdata),
        .data_sram_en     (data_sram_en),
        .data_sram_wen    (data_sram_wen),
        .data_sram_addr   (data_sram_addr),
        .data_sram_wdata  (data_sram_wdata),
        .data_sram_rdata  (data_sram_rdata),
        .data_sram_data_ok(data_sram_data_ok),
        .debug_wb_pc      (debug_wb_pc),
        .debug_wb_rf_wen  (debug_wb_rf_wen),
        .debug_wb_rf_wnum (debug_wb_rf_wnum),
        .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

    sram_model mem0 (
        .clk       (clk),
        .rst       (rst),
        .inst_en   (inst_sram_en),
        .inst_addr (inst_sram_addr),
        .inst_rdata(inst_sram_rdata),
        .data_en   (data_sram_en),
        .data_wen  (data_sram_wen),
        .data_addr (data_sram_addr),
        .data_wdata(data_sram_wdata),
        .data_rdata(data_sram_rdata),
        .data_ok   (data_sram_data_ok)
    );

    always #2 clk = ~clk;

    function automatic word_t rtype(input logic [5:0] fn, input reg_idx_t rs,
                                    input reg_idx_t rt, input reg_idx_t rd);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t itype(input logic [5:0] op, input reg_idx_t rs,
                                    input reg_idx_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t jtype(input word_t target);
        return {OP_J, target[27:2]};
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (exp !== act) begin
            $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_wen(input string name, input wen_t exp, input wen_t act);
        if (exp !== act) begin
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic flag_stray_writeback();
        if (debug_wb_rf_wen != 4'b0000) begin
            $display("unexpected write-back to register %0d at pc %h",
                     debug_wb_rf_wnum, debug_wb_pc);
            errors++;
        end
    endtask

    task automatic build_tables();
        // program at bfc00000, one word per entry
        prog[0]  = itype(OP_LUI,   5'd0,  5'd1,  16'h8000);
        prog[1]  = itype(OP_ORI,   5'd1,  5'd1,  16'h0100);
        prog[2]  = itype(OP_ADDIU, 5'd0,  5'd2,  16'h1234);
        prog[3]  = itype(OP_ADDIU, 5'd0,  5'd3,  16'hfffb);
        prog[4]  = rtype(FN_ADDU,  5'd2,  5'd3,  5'd4);
        prog[5]  = rtype(FN_SUBU,  5'd2,  5'd3,  5'd5);
        prog[6]  = rtype(FN_AND,   5'd2,  5'd3,  5'd6);
        prog[7]  = rtype(FN_OR,    5'd2,  5'd3,  5'd7);
        prog[8]  = rtype(FN_SLT,   5'd3,  5'd2,  5'd8);
        prog[9]  = itype(OP_SW,    5'd1,  5'd4,  16'h0000);
        prog[10] = itype(OP_LW,    5'd1,  5'd9,  16'h0000);
        prog[11] = itype(OP_LW,    5'd1,  5'd10, 16'h0000);
        prog[12] = itype(OP_LUI,   5'd0,  5'd11, 16'ha000);
        prog[13] = itype(OP_LW,    5'd11, 5'd12, 16'h0200);
        prog[14] = itype(OP_LW,    5'd11, 5'd13, 16'h0200);
        prog[15] = itype(OP_ADDIU, 5'd0,  5'd14, 16'h0003);
        prog[16] = itype(OP_ADDIU, 5'd0,  5'd15, 16'h0000);
        // loop body, three passes
        prog[17] = itype(OP_ADDIU, 5'd15, 5'd15, 16'h0007);
        prog[18] = itype(OP_ADDIU, 5'd14, 5'd14, 16'hffff);
        prog[19] = itype(OP_BNE,   5'd14, 5'd0,  16'hfffd);
        prog[20] = itype(OP_SW,    5'd1,  5'd15, 16'h0004);
        prog[21] = jtype(32'hbfc0_0054);

        trace[0]  = '{32'hbfc0_0000, 5'd1,  32'h8000_0000};
        trace[1]  = '{32'hbfc0_0004, 5'd1,  32'h8000_0100};
        trace[2]  = '{32'hbfc0_0008, 5'd2,  32'h0000_1234};
        trace[3]  = '{32'hbfc0_000c, 5'd3,  32'hffff_fffb};
        trace[4]  = '{32'hbfc0_0010, 5'd4,  32'h0000_122f};
        trace[5]  = '{32'hbfc0_0014, 5'd5,  32'h0000_1239};
        trace[6]  = '{32'hbfc0_0018, 5'd6,  32'h0000_1230};
        trace[7]  = '{32'hbfc0_001c, 5'd7,  32'hffff_ffff};
        trace[8]  = '{32'hbfc0_0020, 5'd8,  32'h0000_0001};
        trace[9]  = '{32'hbfc0_0028, 5'd9,  32'h0000_122f};
        trace[10] = '{32'hbfc0_002c, 5'd10, 32'h0000_122f};
        trace[11] = '{32'hbfc0_0030, 5'd11, 32'ha000_0000};
        trace[12] = '{32'hbfc0_0034, 5'd12, KSEG1_WORD};
        trace[13] = '{32'hbfc0_0038, 5'd13, KSEG1_WORD};
        trace[14] = '{32'hbfc0_003c, 5'd14, 32'h0000_0003};
        trace[15] = '{32'hbfc0_0040, 5'd15, 32'h0000_0000};
        for (int k = 0; k < 3; k++) begin
            trace[16 + 2*k] = '{32'hbfc0_0044, 5'd15, word_t'(7 * (k + 1))};
            trace[17 + 2*k] = '{32'hbfc0_0048, 5'd14, word_t'(2 - k)};
        end
    endtask

    task automatic wait_writeback(output logic got);
        int n;
        got = 1'b0;
        n   = 0;
        while (!got && n < WAIT_LIMIT) begin
            @(negedge clk);
            if (debug_wb_rf_wen != 4'b0000) begin
                got = 1'b1;
            end
            n++;
        end
    endtask

    initial begin
        logic got;
        logic done;
        int   n;
        clk      = 1'b0;
        rst     <= 1'b1;
        errors   = 0;
        timeouts = 0;
        build_tables();
        @(posedge clk);
        // program sits at physical 1fc00000, word 0 of the model
        for (int i = 0; i < PROG_LEN; i++) begin
            mem0.imem[i] = prog[i];
        end
        mem0.dmem[IDX_KSEG1] = KSEG1_WORD;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < TRACE_LEN; i++) begin
            wait_writeback(got);
            if (!got) begin
                $display("timeout: write-back %0d of %0d never appeared", i, TRACE_LEN);
                timeouts++;
                break;
            end
            check_word($sformatf("trace %0d pc", i), trace[i].pc, debug_wb_pc);
            check_reg($sformatf("trace %0d wnum", i), trace[i].num, debug_wb_rf_wnum);
            check_word($sformatf("trace %0d wdata", i), trace[i].data, debug_wb_rf_wdata);
            check_wen($sformatf("trace %0d wen", i), 4'b1111, debug_wb_rf_wen);
            check_wen("instruction port wen", 4'b0000, inst_sram_wen);
            check_word("instruction port wdata", 32'h0, inst_sram_wdata);
        end

        // last store and the fetch of the final jump
        n    = 0;
        done = 1'b0;
        while (!done && n < WAIT_LIMIT) begin
            @(negedge clk);
            flag_stray_writeback();
            done = (mem0.data_writes[IDX_RESULT] != 0) && (mem0.inst_reads[PROG_LEN-1] != 0);
            n++;
        end
        if (!done) begin
            $display("timeout: final store or fetch of the jump never happened");
            timeouts++;
        end

        // the jump spins on itself, later passes hit in the i-cache
        for (int i = 0; i < SPIN_CYCLES; i++) begin
            @(negedge clk);
            flag_stray_writeback();
        end

        for (int i = 0; i < PROG_LEN; i++) begin
            check_count($sformatf("fetches of word %0d", i), 1, mem0.inst_reads[i]);
        end
        check_count("reads of cached word", 1, mem0.data_reads[IDX_CACHED]);
        check_count("writes of cached word", 1, mem0.data_writes[IDX_CACHED]);
        check_count("reads of kseg1 word", 2, mem0.data_reads[IDX_KSEG1]);
        check_count("writes of loop result", 1, mem0.data_writes[IDX_RESULT]);
        check_count("instruction addresses off the boot page", 0, mem0.inst_stray);
        check_count("data addresses off the low page", 0, mem0.data_stray);
        check_word("memory at 00000100", 32'h0000_122f, mem0.dmem[IDX_CACHED]);
        check_word("memory at 00000104", 32'h0000_0015, mem0.dmem[IDX_RESULT]);

        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: src.f
common/cpu_pkg.sv
common/fetch_if.sv
common/data_if.sv
datapath/regfile.sv
datapath/datapath.sv
cache/i_cache.sv
cache/d_cache.sv
src/mycpu_top.sv
bench/sram_model.sv
bench/tb_top.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary -j 0 --top-module tb_top -f src.f --Mdir "$OBJ" -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
    exit 1
fi
exit 0
